//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Architectural register file
`define NUM_REGS 32

// Direct-mapped, one word per line
`define DCACHE_LINES 16

// Backing RAM size in words, addresses wrap at 1 KiB
`define DMEM_WORDS 256

// Cycles from miss seen to line valid, at least 2
`define REFILL_LATENCY 3

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] u32_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } byte_type_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_LOAD_MISALIGN,
        EXC_STORE_MISALIGN
    } excp_cause_t;

    typedef struct packed {
        logic        valid;
        excp_cause_t cause;
        u32_t        addr;    // Faulting address
    } excp_pass_t;

    typedef struct packed {
        logic       is_flush;    // Bubble
        u32_t       pc;
        logic [4:0] rd;
        logic       is_wr_rd;
        logic       is_mem;      // Aligned load
        byte_type_t byte_type;
        logic [1:0] byte_en;     // Address bits [1:0]
        logic       is_signed;
        u32_t       ex_out;
    } memory1_memory2_pass_t;

    typedef struct packed {
        logic       is_flush;
        u32_t       pc;
        logic [4:0] rd;
        logic       is_wr_rd;
        u32_t       ex_mem_out;
    } memory2_writeback_pass_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] idx;
        u32_t       data;
    } forward_req_t;

endpackage

`default_nettype wire

//--- verilog/dcache_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dcache_if;
    import cpu_pkg::*;

    logic       req;
    logic       we;
    u32_t       addr;
    u32_t       wdata;
    logic [3:0] wstrb;
    logic       ready;    // Access in memory2 is done
    u32_t       rdata;

    modport requester (
        output req, we, addr, wdata, wstrb
    );

    modport responder (
        input ready, rdata
    );

    modport cache (
        input  req, we, addr, wdata, wstrb,
        output ready, rdata
    );

endinterface

`default_nettype wire

//--- verilog/memory1_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory1_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  cpu_pkg::u32_t                  in_pc,
    input  cpu_pkg::u32_t                  in_ex_out,
    input  cpu_pkg::u32_t                  in_store_data,
    input  logic [4:0]                     in_rd,
    input  logic                           in_is_wr_rd,
    input  cpu_pkg::mem_op_t               in_op,
    input  cpu_pkg::byte_type_t            in_byte_type,
    input  logic                           in_is_signed,
    input  logic                           is_stall,
    input  logic                           is_flush,
    dcache_if.requester                    dc,
    output cpu_pkg::memory1_memory2_pass_t pass_out,
    output cpu_pkg::excp_pass_t            excp_pass_out
);
    import cpu_pkg::*;

    logic       valid_r;
    u32_t       pc_r;
    u32_t       ex_out_r;
    u32_t       store_data_r;
    logic [4:0] rd_r;
    logic       is_wr_rd_r;
    mem_op_t    op_r;
    byte_type_t byte_type_r;
    logic       is_signed_r;

    logic misalign;
    logic is_mem_op;
    logic is_bad;

    assign in_ready = ~is_stall;

    always_ff @(posedge clk) begin
        if (!rst_n || is_flush) begin
            valid_r <= 1'b0;
        end else if (!is_stall) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!is_stall) begin
            pc_r         <= in_pc;
            ex_out_r     <= in_ex_out;
            store_data_r <= in_store_data;
            rd_r         <= in_rd;
            is_wr_rd_r   <= in_is_wr_rd;
            op_r         <= in_op;
            byte_type_r  <= in_byte_type;
            is_signed_r  <= in_is_signed;
        end
    end

    always_comb begin
        case (byte_type_r)
            HALF_WORD: misalign = ex_out_r[0];
            WORD:      misalign = |ex_out_r[1:0];
            default:   misalign = 1'b0;
        endcase
    end

    assign is_mem_op = valid_r & (op_r != MEM_NONE);
    assign is_bad    = is_mem_op & misalign;

    // Store data replicated so every lane holds it, wstrb picks the lanes
    always_comb begin
        case (byte_type_r)
            BYTE: begin
                dc.wstrb = 4'b0001 << ex_out_r[1:0];
                dc.wdata = {4{store_data_r[7:0]}};
            end
            HALF_WORD: begin
                dc.wstrb = ex_out_r[1] ? 4'b1100 : 4'b0011;
                dc.wdata = {2{store_data_r[15:0]}};
            end
            default: begin
                dc.wstrb = 4'b1111;
                dc.wdata = store_data_r;
            end
        endcase
    end

    assign dc.req  = is_mem_op & ~misalign;
    assign dc.we   = (op_r == MEM_STORE);
    assign dc.addr = ex_out_r;

    assign pass_out.is_flush  = ~valid_r;
    assign pass_out.pc        = pc_r;
    assign pass_out.rd        = rd_r;
    assign pass_out.is_wr_rd  = is_wr_rd_r & ~is_bad;
    assign pass_out.is_mem    = (op_r == MEM_LOAD) & ~misalign;
    assign pass_out.byte_type = byte_type_r;
    assign pass_out.byte_en   = ex_out_r[1:0];
    assign pass_out.is_signed = is_signed_r;
    assign pass_out.ex_out    = ex_out_r;

    assign excp_pass_out.valid = is_bad;
    assign excp_pass_out.cause = !is_bad ? EXC_NONE :
                                 (op_r == MEM_STORE) ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
    assign excp_pass_out.addr  = ex_out_r;

endmodule

`default_nettype wire

//--- verilog/dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module dcache (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    is_stall,
    input  logic    is_flush,
    dcache_if.cache dc
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(`DCACHE_LINES);
    localparam int RAM_W = $clog2(`DMEM_WORDS);
    localparam int TAG_W = RAM_W - IDX_W;
    localparam int CNT_W = $clog2(`REFILL_LATENCY);

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_LOOKUP,
        DC_REFILL
    } dcache_state_t;

    dcache_state_t            state;
    logic [`DCACHE_LINES-1:0] line_valid;
    logic [TAG_W-1:0]         line_tag [`DCACHE_LINES];
    u32_t                     line_data [`DCACHE_LINES];
    u32_t                     ram [`DMEM_WORDS];

    logic [RAM_W-1:0] clr_cnt;
    logic             clearing;
    logic [CNT_W-1:0] refill_cnt;
    logic [RAM_W-1:0] lk_word;    // Access sitting in memory2
    logic             lk_we;
    logic [RAM_W-1:0] fill_word;
    logic [RAM_W-1:0] in_word;
    logic             sample;
    logic             in_hit;
    logic             lk_hit;
    logic             lk_miss;
    logic             fill_done;
    logic             st_sample;

    function automatic logic is_hit(input logic [RAM_W-1:0] word);
        return line_valid[word[IDX_W-1:0]] && line_tag[word[IDX_W-1:0]] == word[RAM_W-1:IDX_W];
    endfunction

    function automatic u32_t merge(input u32_t old, input u32_t wd, input logic [3:0] st);
        u32_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    assign in_word   = dc.addr[RAM_W+1:2];
    assign sample    = dc.req & ~is_stall & ~is_flush;
    assign st_sample = sample & dc.we;
    assign in_hit    = is_hit(in_word);
    assign lk_hit    = is_hit(lk_word);
    assign lk_miss   = (state == DC_LOOKUP) & ~lk_we & ~lk_hit;
    assign fill_done = (state == DC_REFILL) & (refill_cnt == '0);

    assign dc.ready = (state == DC_LOOKUP) & (lk_we | lk_hit);
    assign dc.rdata = line_data[lk_word[IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_cnt  <= '0;
            clearing <= 1'b1;
        end else if (clearing) begin
            clr_cnt  <= clr_cnt + 1'b1;
            clearing <= (clr_cnt != RAM_W'(`DMEM_WORDS - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            ram[clr_cnt] <= '0;
        end else if (st_sample) begin
            ram[in_word] <= merge(ram[in_word], dc.wdata, dc.wstrb);    // Write-through
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= DC_IDLE;
            line_valid <= '0;
        end else begin
            case (state)
                DC_REFILL: begin
                    if (fill_done) begin
                        state                               <= DC_LOOKUP;
                        line_valid[fill_word[IDX_W-1:0]] <= 1'b1;
                    end
                end
                DC_LOOKUP: begin
                    if (sample) state <= DC_LOOKUP;
                    else if (lk_miss) state <= DC_REFILL;
                    else state <= DC_IDLE;
                end
                default: state <= sample ? DC_LOOKUP : DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            lk_word <= in_word;
            lk_we   <= dc.we;
        end
        if (lk_miss && !sample) begin
            fill_word  <= lk_word;
            refill_cnt <= CNT_W'(`REFILL_LATENCY - 2);
        end else if (state == DC_REFILL) begin
            refill_cnt <= refill_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (st_sample && in_hit) begin
            line_data[in_word[IDX_W-1:0]] <= merge(line_data[in_word[IDX_W-1:0]],
                                                   dc.wdata, dc.wstrb);
        end
        if (fill_done) begin    // Store to the same word in this edge wins
            line_tag[fill_word[IDX_W-1:0]]  <= fill_word[RAM_W-1:IDX_W];
            line_data[fill_word[IDX_W-1:0]] <= (st_sample && in_word == fill_word) ?
                merge(ram[fill_word], dc.wdata, dc.wstrb) : ram[fill_word];
        end
    end

endmodule

`default_nettype wire

//--- verilog/memory2_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory2_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             dcache_ready,
    input  cpu_pkg::u32_t                    rd_dcache_data,
    input  logic                             is_stall,
    input  logic                             is_flush,
    input  cpu_pkg::memory1_memory2_pass_t   pass_in,
    input  cpu_pkg::excp_pass_t              excp_pass_in,
    output cpu_pkg::forward_req_t            fwd_req,
    output logic                             dcache_stall,
    output cpu_pkg::memory2_writeback_pass_t pass_out,
    output cpu_pkg::excp_pass_t              excp_pass_out
);
    import cpu_pkg::*;

    memory1_memory2_pass_t pass_in_r;
    excp_pass_t            excp_pass_in_r;

    logic        mem2_flush;
    logic [7:0]  mem_byte;
    logic [15:0] mem_half_word;
    u32_t        mem_out;
    u32_t        ex_mem_out;

    always_ff @(posedge clk) begin
        if (!rst_n || is_flush) begin
            pass_in_r.is_flush   <= 1'b1;
            excp_pass_in_r.valid <= 1'b0;
        end else if (!is_stall) begin
            pass_in_r      <= pass_in;
            excp_pass_in_r <= excp_pass_in;
        end
    end

    assign mem2_flush = is_flush | pass_in_r.is_flush;

    always_comb begin
        case (pass_in_r.byte_en)
            2'b00:   mem_byte = rd_dcache_data[7:0];
            2'b01:   mem_byte = rd_dcache_data[15:8];
            2'b10:   mem_byte = rd_dcache_data[23:16];
            default: mem_byte = rd_dcache_data[31:24];
        endcase
    end

    assign mem_half_word = pass_in_r.byte_en[1] ? rd_dcache_data[31:16] : rd_dcache_data[15:0];

    always_comb begin
        case (pass_in_r.byte_type)
            BYTE:      mem_out = {{24{pass_in_r.is_signed & mem_byte[7]}}, mem_byte};
            HALF_WORD: mem_out = {{16{pass_in_r.is_signed & mem_half_word[15]}}, mem_half_word};
            default:   mem_out = rd_dcache_data;
        endcase
    end

    assign ex_mem_out = pass_in_r.is_mem ? mem_out : pass_in_r.ex_out;

    assign dcache_stall = ~dcache_ready & pass_in_r.is_mem & ~mem2_flush;

    // Bubble to writeback while waiting on the cache
    assign pass_out.is_flush   = mem2_flush | dcache_stall;
    assign pass_out.pc         = pass_in_r.pc;
    assign pass_out.rd         = pass_in_r.rd;
    assign pass_out.is_wr_rd   = pass_in_r.is_wr_rd;
    assign pass_out.ex_mem_out = ex_mem_out;

    assign fwd_req.valid = ~pass_out.is_flush & pass_in_r.is_wr_rd;
    assign fwd_req.idx   = pass_in_r.rd;
    assign fwd_req.data  = ex_mem_out;

    assign excp_pass_out.valid = excp_pass_in_r.valid & ~pass_out.is_flush;
    assign excp_pass_out.cause = excp_pass_in_r.cause;
    assign excp_pass_out.addr  = excp_pass_in_r.addr;

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module writeback_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  cpu_pkg::memory2_writeback_pass_t pass_in,
    input  cpu_pkg::excp_pass_t              excp_pass_in,
    output logic                             wb_valid,
    output cpu_pkg::u32_t                    wb_pc,
    output logic [4:0]                       wb_rd,
    output cpu_pkg::u32_t                    wb_data,
    output logic                             excp_valid,
    output cpu_pkg::excp_cause_t             excp_cause,
    output cpu_pkg::u32_t                    excp_addr,
    input  logic [4:0]                       rf_raddr,
    output cpu_pkg::u32_t                    rf_rdata
);
    import cpu_pkg::*;

    memory2_writeback_pass_t pass_r;
    excp_pass_t              excp_r;
    u32_t                    regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pass_r.is_flush <= 1'b1;
            excp_r.valid    <= 1'b0;
        end else begin
            pass_r <= pass_in;
            excp_r <= excp_pass_in;
        end
    end

    // Written together with the stage register so rf matches wb_*
    always_ff @(posedge clk) begin
        if (rst_n && !pass_in.is_flush && pass_in.is_wr_rd && pass_in.rd != 5'd0) begin
            regs[pass_in.rd] <= pass_in.ex_mem_out;
        end
    end

    assign rf_rdata = (rf_raddr == 5'd0) ? '0 : regs[rf_raddr];

    assign wb_valid   = ~pass_r.is_flush;
    assign wb_pc      = pass_r.pc;
    assign wb_rd      = pass_r.rd;
    assign wb_data    = pass_r.ex_mem_out;
    assign excp_valid = excp_r.valid;
    assign excp_cause = excp_r.cause;
    assign excp_addr  = excp_r.addr;

endmodule

`default_nettype wire

//--- verilog/mem_backend_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_backend_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  cpu_pkg::u32_t        in_pc,
    input  cpu_pkg::u32_t        in_ex_out,
    input  cpu_pkg::u32_t        in_store_data,
    input  logic [4:0]           in_rd,
    input  logic                 in_is_wr_rd,
    input  cpu_pkg::mem_op_t     in_op,
    input  cpu_pkg::byte_type_t  in_byte_type,
    input  logic                 in_is_signed,
    input  logic                 flush,
    output logic                 fwd_valid,
    output logic [4:0]           fwd_idx,
    output cpu_pkg::u32_t        fwd_data,
    output logic                 dcache_stall,
    output logic                 wb_valid,
    output cpu_pkg::u32_t        wb_pc,
    output logic [4:0]           wb_rd,
    output cpu_pkg::u32_t        wb_data,
    output logic                 excp_valid,
    output cpu_pkg::excp_cause_t excp_cause,
    output cpu_pkg::u32_t        excp_addr,
    input  logic [4:0]           rf_raddr,
    output cpu_pkg::u32_t        rf_rdata
);
    import cpu_pkg::*;

    memory1_memory2_pass_t   mem1_pass;
    excp_pass_t              mem1_excp;
    memory2_writeback_pass_t mem2_pass;
    excp_pass_t              mem2_excp;
    forward_req_t            fwd_req;

    dcache_if dc_bus ();

    memory1_stage u_memory1 (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_ex_out     (in_ex_out),
        .in_store_data (in_store_data),
        .in_rd         (in_rd),
        .in_is_wr_rd   (in_is_wr_rd),
        .in_op         (in_op),
        .in_byte_type  (in_byte_type),
        .in_is_signed  (in_is_signed),
        .is_stall      (dcache_stall),
        .is_flush      (flush),
        .dc            (dc_bus.requester),
        .pass_out      (mem1_pass),
        .excp_pass_out (mem1_excp)
    );

    dcache u_dcache (
        .clk      (clk),
        .rst_n    (rst_n),
        .is_stall (dcache_stall),
        .is_flush (flush),
        .dc       (dc_bus.cache)
    );

    memory2_stage u_memory2 (
        .clk            (clk),
        .rst_n          (rst_n),
        .dcache_ready   (dc_bus.ready),
        .rd_dcache_data (dc_bus.rdata),
        .is_stall       (dcache_stall),
        .is_flush       (flush),
        .pass_in        (mem1_pass),
        .excp_pass_in   (mem1_excp),
        .fwd_req        (fwd_req),
        .dcache_stall   (dcache_stall),
        .pass_out       (mem2_pass),
        .excp_pass_out  (mem2_excp)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .pass_in      (mem2_pass),
        .excp_pass_in (mem2_excp),
        .wb_valid     (wb_valid),
        .wb_pc        (wb_pc),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .excp_valid   (excp_valid),
        .excp_cause   (excp_cause),
        .excp_addr    (excp_addr),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata)
    );

    assign fwd_valid = fwd_req.valid;
    assign fwd_idx   = fwd_req.idx;
    assign fwd_data  = fwd_req.data;

endmodule

`default_nettype wire

//--- verification/mem_backend_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module mem_backend_checker (
    input logic clk,
    input logic rst_n,
    input logic in_ready,
    input logic dcache_stall,
    input logic wb_valid
);

    int fail_cnt = 0;    // Failed assertions so far

    // Upstream sees the cache stall directly
    ready_follows_stall: assert property (
        @(posedge clk) disable iff (!rst_n) in_ready == !dcache_stall
    ) else begin
        fail_cnt++;
        $error("in_ready does not mirror dcache_stall");
    end

    no_wb_in_reset: assert property (
        @(posedge clk) !rst_n |=> !wb_valid
    ) else begin
        fail_cnt++;
        $error("wb_valid high during reset");
    end

    no_wb_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !wb_valid ##1 !wb_valid
    ) else begin
        fail_cnt++;
        $error("wb_valid high right after reset");
    end

    // Refill bounds the stall
    stall_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(dcache_stall) |-> ##[1:`REFILL_LATENCY+1] !dcache_stall
    ) else begin
        fail_cnt++;
        $error("dcache_stall held too long");
    end

endmodule

bind mem_backend_top mem_backend_checker u_checker (.*);

`default_nettype wire

//--- verification/mem_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_settings.svh"

module mem_backend_tb;
    import cpu_pkg::*;

    typedef struct {
        u32_t        pc;
        u32_t        data;
        logic        excp;
        excp_cause_t cause;
        u32_t        addr;
        logic        wr;
        logic [4:0]  rd;
        int          acc_cyc;
        int          acc_stalls;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid, in_is_wr_rd, in_is_signed, flush;
    u32_t in_pc, in_ex_out, in_store_data;
    logic [4:0] in_rd, rf_raddr;
    mem_op_t in_op;
    byte_type_t in_byte_type;
    logic in_ready, fwd_valid, dcache_stall, wb_valid, excp_valid;
    logic [4:0] fwd_idx, wb_rd;
    u32_t fwd_data, wb_pc, wb_data, excp_addr, rf_rdata;
    excp_cause_t excp_cause;

    exp_t exp_q[$];
    u32_t mem_model [`DMEM_WORDS];
    u32_t reg_model [`NUM_REGS];
    logic [`NUM_REGS-1:0] reg_known = 1;    // Register 0 reads zero
    logic [`DCACHE_LINES-1:0] line_ok = '0;
    logic [3:0] line_tag_m [`DCACHE_LINES];
    int   errors = 0;
    int   checks = 0;
    int   cyc = 0;
    int   stalls = 0;
    int   stall_len = 0;
    int   stall_runs = 0;
    int   misses = 0;
    logic last_flush = 1'b0;
    logic fwd_pend = 1'b0;
    logic [4:0] fwd_pidx;
    u32_t fwd_pdata;

    mem_backend_top dut0 (.*);

    always #10 clk = ~clk;

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    function automatic u32_t load_value(u32_t w, u32_t a, byte_type_t bt, logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        if (bt == BYTE) return {{24{sgn & b[7]}}, b};
        if (bt == HALF_WORD) return {{16{sgn & h[15]}}, h};
        return w;
    endfunction

    function automatic u32_t store_merge(u32_t w, u32_t a, byte_type_t bt, u32_t d);
        u32_t r;
        r = w;
        if (bt == BYTE) r[8*a[1:0] +: 8] = d[7:0];
        else if (bt == HALF_WORD) r[16*a[1] +: 16] = d[15:0];
        else r = d;
        return r;
    endfunction

    task automatic record_accept();
        exp_t e;
        logic bad;
        bad = (in_op != MEM_NONE) &&
              ((in_byte_type == HALF_WORD && in_ex_out[0]) ||
               (in_byte_type == WORD && in_ex_out[1:0] != 2'b00));
        e.pc = in_pc;
        e.data = in_ex_out;
        e.excp = bad;
        e.cause = !bad ? EXC_NONE :
                  (in_op == MEM_STORE) ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
        e.addr = in_ex_out;
        e.wr = in_is_wr_rd && !bad;
        e.rd = in_rd;
        e.acc_cyc = cyc;
        e.acc_stalls = stalls;
        if (!bad && in_op == MEM_LOAD) begin
            e.data = load_value(mem_model[in_ex_out[9:2]], in_ex_out, in_byte_type, in_is_signed);
            if (!line_ok[in_ex_out[5:2]] || line_tag_m[in_ex_out[5:2]] != in_ex_out[9:6]) begin
                misses++;    // Refill allocates the line
                line_ok[in_ex_out[5:2]] = 1'b1;
                line_tag_m[in_ex_out[5:2]] = in_ex_out[9:6];
            end
        end else if (!bad && in_op == MEM_STORE) begin
            mem_model[in_ex_out[9:2]] = store_merge(mem_model[in_ex_out[9:2]], in_ex_out,
                                                    in_byte_type, in_store_data);
        end
        exp_q.push_back(e);
    endtask

    // Reference model follows the accepted stream
    always @(posedge clk) begin
        cyc++;
        last_flush = flush;
        if (rst_n) begin
            if (dcache_stall) begin
                stalls++;
                stall_len++;
            end else if (stall_len != 0) begin
                checks++;
                stall_runs++;
                assert (stall_len == `REFILL_LATENCY)
                    else flag_mismatch($sformatf("stall lasted %0d cycles", stall_len));
                stall_len = 0;
            end
            if (flush) exp_q.delete();    // Nothing inside the DUT survives
            else if (in_valid && in_ready) record_accept();
        end
    end

    always @(negedge clk) begin
        exp_t e;
        if (rst_n) begin
            if (fwd_pend && !last_flush) begin
                checks++;
                assert (wb_valid && wb_rd == fwd_pidx && wb_data == fwd_pdata)
                    else flag_mismatch($sformatf("forward %0d=%h not seen on wb",
                                                 fwd_pidx, fwd_pdata));
            end
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected result on wb_valid at %0t", $time);
                end else begin
                    e = exp_q.pop_front();
                    checks++;
                    assert (wb_pc == e.pc && wb_rd == e.rd && wb_data == e.data)
                        else flag_mismatch($sformatf("pc %h rd %0d data %h, expected %h %0d %h",
                                                     wb_pc, wb_rd, wb_data, e.pc, e.rd, e.data));
                    assert (fwd_pend == e.wr)
                        else flag_mismatch($sformatf("fwd_valid wrong for pc %h", e.pc));
                    assert (excp_valid == e.excp && (!e.excp ||
                            (excp_cause == e.cause && excp_addr == e.addr)))
                        else flag_mismatch($sformatf("exception at pc %h wrong", e.pc));
                    // memory1, memory2, writeback, plus one per stall cycle
                    assert (cyc == e.acc_cyc + 2 + stalls - e.acc_stalls)
                        else flag_mismatch($sformatf("latency wrong for pc %h", e.pc));
                    if (e.wr && e.rd != 5'd0) begin
                        reg_model[e.rd] = e.data;
                        reg_known[e.rd] = 1'b1;
                    end
                end
            end else begin
                assert (!excp_valid) else flag_mismatch("excp_valid without wb_valid");
            end
            if (reg_known[rf_raddr]) begin
                checks++;
                assert (rf_rdata == reg_model[rf_raddr])
                    else flag_mismatch($sformatf("rf[%0d] = %h, expected %h",
                                                 rf_raddr, rf_rdata, reg_model[rf_raddr]));
            end
            fwd_pend = fwd_valid;
            fwd_pidx = fwd_idx;
            fwd_pdata = fwd_data;
        end
    end

    task automatic pick_op(input logic plain_only);
        int r;
        byte_type_t bt;
        u32_t a;
        r = plain_only ? 0 : $urandom % 10;
        bt = byte_type_t'($urandom % 3);
        a = $urandom % 256;    // Four tags share each line
        if ($urandom % 8 != 0) begin
            if (bt == HALF_WORD) a[0] = 1'b0;
            if (bt == WORD) a[1:0] = 2'b00;
        end
        in_valid <= 1'b1;
        in_pc <= in_pc + 4;
        in_op <= (r < 3) ? MEM_NONE : (r < 6) ? MEM_STORE : MEM_LOAD;
        in_ex_out <= (r < 3) ? $urandom : a;
        in_store_data <= $urandom;
        in_byte_type <= bt;
        in_is_signed <= $urandom % 2;
        in_rd <= $urandom % 32;
        in_is_wr_rd <= (r < 3) || (r >= 6);
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (t >= 200) begin
            errors++;
            $display("Results did not drain in time");
        end
    endtask

    always @(posedge clk) rf_raddr <= $urandom % 32;

    initial begin
        int t;
        int sent;
        void'($urandom(32'h31cc379f));
        foreach (mem_model[i]) mem_model[i] = '0;
        foreach (reg_model[i]) reg_model[i] = '0;
        rst_n = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_ex_out = '0;
        in_store_data = '0;
        in_rd = '0;
        in_is_wr_rd = 1'b0;
        in_op = MEM_NONE;
        in_byte_type = WORD;
        in_is_signed = 1'b0;
        rf_raddr = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        t = 0;
        while (t < 260) begin    // Backing RAM clear
            @(posedge clk);
            t++;
        end
        sent = 0;
        t = 0;
        while (sent < 400 && t < 20000) begin
            @(posedge clk);
            t++;
            if (in_valid && in_ready) sent++;
            if (!in_valid || in_ready) begin
                if ($urandom % 5 != 0) pick_op(1'b0);
                else in_valid <= 1'b0;
            end
        end
        if (t >= 20000) begin
            errors++;
            $display("Random stimulus stalled out");
        end
        @(posedge clk) in_valid <= 1'b0;
        drain();
        repeat (6) begin
            @(posedge clk) pick_op(1'b1);
            @(posedge clk) pick_op(1'b1);
            @(posedge clk);
            in_valid <= 1'b0;
            flush <= 1'b1;
            @(posedge clk) flush <= 1'b0;
            repeat (5) @(posedge clk);
            drain();
        end
        checks++;
        assert (stall_runs == misses)
            else flag_mismatch($sformatf("%0d stalls for %0d predicted misses",
                                         stall_runs, misses));
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.u_checker.fail_cnt);
        if (errors == 0 && dut0.u_checker.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #2000000;
        $display("Simulation ran past its time limit");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/cpu_pkg.sv
verilog/dcache_if.sv
verilog/memory1_stage.sv
verilog/dcache.sv
verilog/memory2_stage.sv
verilog/writeback_stage.sv
verilog/mem_backend_top.sv
verification/mem_backend_checker.sv
verification/mem_backend_tb.sv
